/* hdl/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage (
    input  logic                    i_clock,
    input  logic                    i_reset,
    // from IF/ID
    input  fetchPkg::fetchItem_t    i_item,
    input  logic                    i_itemValid,
    output logic                    o_itemReady,
    input  logic                    i_redirect,
    // consumer side
    output fetchPkg::decodedInstr_t o_decoded,
    output logic                    o_valid,
    input  logic                    i_ready
);

    fetchPkg::instrWord_t    word;
    fetchPkg::decodedInstr_t dec;
    fetchPkg::decodedInstr_t outR;
    logic                    validR;
    logic                    accept;

    // output empty or being emptied, never during a flush
    assign o_itemReady = (!validR || i_ready) && !i_redirect;
    assign accept      = i_itemValid && o_itemReady;

    always_comb begin
        // faulted items decode as a zero word
        word       = i_item.fault ? '0 : i_item.instr;
        dec.pc     = i_item.pc;
        dec.opcode = word[31:26];
        dec.rs     = word[25:21];
        dec.rt     = word[20:16];
        dec.rd     = word[15:11];
        dec.shamt  = word[10:6];
        dec.funct  = word[5:0];
        // sign extend from bit 15
        dec.immExt = {{16{word[15]}}, word[15:0]};
        dec.fault  = i_item.fault;
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            validR <= 1'b0;
        end else if (accept) begin
            validR <= 1'b1;
        end else if (i_ready) begin
            validR <= 1'b0;
        end
    end

    // held still while the consumer stalls
    always_ff @(posedge i_clock) begin
        if (accept) begin
            outR <= dec;
        end
    end

    assign o_decoded = outR;
    assign o_valid   = validR;

endmodule

/* hdl/fetchPkg.sv */
package fetchPkg;

    // byte address and raw instruction word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] instrWord_t;

    // mips field widths
    typedef logic [5:0] opcode_t;
    typedef logic [4:0] regIdx_t;
    typedef logic [5:0] funct_t;
    typedef logic [4:0] shamt_t;

    // wishbone classic, master to slave
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        addr_t adr;
    } wbReq_t;

    // wishbone classic, slave to master
    typedef struct packed {
        logic       ack;
        logic       err;
        instrWord_t dat;
    } wbRsp_t;

    // IF/ID register content
    typedef struct packed {
        addr_t      pc;
        instrWord_t instr;
        logic       fault;
    } fetchItem_t;

    // decode output register content
    typedef struct packed {
        addr_t      pc;
        opcode_t    opcode;
        regIdx_t    rs;
        regIdx_t    rt;
        regIdx_t    rd;
        shamt_t     shamt;
        funct_t     funct;
        instrWord_t immExt;
        logic       fault;
    } decodedInstr_t;

    // program rom contents, word a holds entry a mod 4
    localparam instrWord_t [0:3] INIT_PATTERN = '{
        32'hCCDDEEFF,
        32'h11223344,
        32'hAABBCCDD,
        32'h55667788
    };

endpackage

/* hdl/fetchStage.sv */
`timescale 1ns/1ps

module fetchStage (
    input  logic                 i_clock,
    input  logic                 i_reset,
    // pc handshake
    input  fetchPkg::addr_t      i_pc,
    output logic                 o_takePc,
    input  logic                 i_redirect,
    // wishbone master
    output fetchPkg::wbReq_t     o_wbReq,
    input  fetchPkg::wbRsp_t     i_wbRsp,
    // IF/ID towards decode
    output fetchPkg::fetchItem_t o_item,
    output logic                 o_itemValid,
    input  logic                 i_itemReady
);

    // IDLE no bus cycle and IF/ID empty
    // BUS strobe out, waiting on ack or err
    // DRAIN IF/ID full, next cycle held back
    typedef enum logic [1:0] {IDLE, BUS, DRAIN} state_t;

    state_t               state;
    state_t               stateNext;
    logic                 cycR;
    logic                 stbR;
    fetchPkg::addr_t      adrR;
    fetchPkg::fetchItem_t itemR;
    logic                 itemValidR;
    logic                 squashR;
    logic                 answer;
    logic                 capture;
    logic                 idFree;
    logic                 startBus;

    always_comb begin
        answer  = (state == BUS) && (i_wbRsp.ack || i_wbRsp.err);
        // squashed cycles are dropped when they answer
        capture = answer && !squashR && !i_redirect;
        // IF/ID empty after this edge
        idFree  = !itemValidR || i_itemReady;
        if (state == BUS) begin
            // back to back only if the captured word is sure to move on next edge
            startBus = answer && (capture ? (!itemValidR && i_itemReady) : idFree);
        end else begin
            startBus = idFree;
        end
        // pc is loading the target this cycle
        startBus = startBus && !i_redirect;
    end

    always_comb begin
        stateNext = state;
        case (state)
            IDLE: begin
                if (startBus) stateNext = BUS;
            end
            BUS: begin
                if (answer) begin
                    if (startBus) stateNext = BUS;
                    else if (capture) stateNext = DRAIN;
                    else stateNext = IDLE;
                end
            end
            DRAIN: begin
                if (startBus) stateNext = BUS;
                else if (i_redirect) stateNext = IDLE;
            end
            default: stateNext = IDLE;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state      <= IDLE;
            cycR       <= 1'b0;
            stbR       <= 1'b0;
            squashR    <= 1'b0;
            itemValidR <= 1'b0;
        end else begin
            state <= stateNext;
            // strobe held until the answer edge
            if (startBus) begin
                cycR <= 1'b1;
                stbR <= 1'b1;
            end else if (answer) begin
                cycR <= 1'b0;
                stbR <= 1'b0;
            end
            if (answer) begin
                squashR <= 1'b0;
            end else if (i_redirect && state == BUS) begin
                squashR <= 1'b1;
            end
            // flush on redirect
            if (i_redirect) begin
                itemValidR <= 1'b0;
            end else if (capture) begin
                itemValidR <= 1'b1;
            end else if (i_itemReady) begin
                itemValidR <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (startBus) begin
            adrR <= i_pc;
        end
        // adr doubles as the pc of the cycle
        if (capture) begin
            itemR.pc    <= adrR;
            itemR.instr <= i_wbRsp.dat;
            itemR.fault <= i_wbRsp.err;
        end
    end

    always_comb begin
        o_wbReq.cyc = cycR;
        o_wbReq.stb = stbR;
        o_wbReq.we  = 1'b0;
        o_wbReq.adr = adrR;
    end

    assign o_takePc    = startBus;
    assign o_item      = itemR;
    assign o_itemValid = itemValidR;

endmodule

/* hdl/instrFetchTop.sv */
`timescale 1ns/1ps

module instrFetchTop #(
    parameter int              RAM_DEPTH = 64,
    parameter fetchPkg::addr_t RESET_PC  = 32'h0
) (
    input  logic                    i_clock,
    input  logic                    i_reset,
    input  logic                    i_redirect,
    input  fetchPkg::addr_t         i_redirectPc,
    input  logic                    i_ready,
    output logic                    o_valid,
    output fetchPkg::decodedInstr_t o_decoded
);

    fetchPkg::addr_t      pc;
    logic                 takePc;
    fetchPkg::wbReq_t     wbReq;
    fetchPkg::wbRsp_t     wbRsp;
    fetchPkg::fetchItem_t item;
    logic                 itemValid;
    logic                 itemReady;

    // next fetch address
    programCounter #(
        .RESET_PC(RESET_PC)
    ) u_pc (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_redirect  (i_redirect),
        .i_redirectPc(i_redirectPc),
        .i_takePc    (takePc),
        .o_pc        (pc)
    );

    // bus master and IF/ID
    fetchStage u_fetch (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_pc       (pc),
        .o_takePc   (takePc),
        .i_redirect (i_redirect),
        .o_wbReq    (wbReq),
        .i_wbRsp    (wbRsp),
        .o_item     (item),
        .o_itemValid(itemValid),
        .i_itemReady(itemReady)
    );

    // program rom as the bus slave
    instructionMemory #(
        .RAM_DEPTH(RAM_DEPTH)
    ) u_imem (
        .i_clock(i_clock),
        .i_reset(i_reset),
        .i_wbReq(wbReq),
        .o_wbRsp(wbRsp)
    );

    // field split and output register
    decodeStage u_decode (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_item     (item),
        .i_itemValid(itemValid),
        .o_itemReady(itemReady),
        .i_redirect (i_redirect),
        .o_decoded  (o_decoded),
        .o_valid    (o_valid),
        .i_ready    (i_ready)
    );

endmodule

/* hdl/instructionMemory.sv */
`timescale 1ns/1ps

module instructionMemory #(
    parameter int RAM_DEPTH = 64
) (
    input  logic             i_clock,
    input  logic             i_reset,
    // wishbone classic slave port, read only
    input  fetchPkg::wbReq_t i_wbReq,
    output fetchPkg::wbRsp_t o_wbRsp
);

    localparam int ADDR_W = $clog2(RAM_DEPTH);

    fetchPkg::instrWord_t mem [RAM_DEPTH];

    logic [29:0]          wordIdx;
    logic [ADDR_W-1:0]    memIdx;
    logic                 inRange;
    logic                 accept;
    logic                 ackR;
    logic                 errR;
    fetchPkg::instrWord_t datR;

    // word index from bit 2 upward
    assign wordIdx = i_wbReq.adr[31:2];
    assign memIdx  = wordIdx[ADDR_W-1:0];
    assign inRange = wordIdx < RAM_DEPTH;

    // new strobe only, the cycle after an answer still shows the old one
    assign accept = i_wbReq.cyc && i_wbReq.stb && !(ackR || errR);

    // pattern fill on reset, repeats every four words
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 0; i < RAM_DEPTH; i++) begin
                mem[i] <= fetchPkg::INIT_PATTERN[i % 4];
            end
        end
    end

    // registered read
    always_ff @(posedge i_clock) begin
        if (accept) begin
            // out of range reads back as zero
            datR <= inRange ? mem[memIdx] : '0;
        end
    end

    // one answer per strobe, a cycle after it is seen
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            ackR <= 1'b0;
            errR <= 1'b0;
        end else begin
            ackR <= accept && inRange;
            errR <= accept && !inRange;
        end
    end

    always_comb begin
        o_wbRsp.ack = ackR;
        o_wbRsp.err = errR;
        o_wbRsp.dat = datR;
    end

endmodule

/* hdl/programCounter.sv */
`timescale 1ns/1ps

module programCounter #(
    parameter fetchPkg::addr_t RESET_PC = 32'h0
) (
    input  logic            i_clock,
    input  logic            i_reset,
    // branch redirect from outside
    input  logic            i_redirect,
    input  fetchPkg::addr_t i_redirectPc,
    // fetch stage starts a bus cycle with o_pc
    input  logic            i_takePc,
    output fetchPkg::addr_t o_pc
);

    fetchPkg::addr_t pcR;
    fetchPkg::addr_t pcNext;
    fetchPkg::addr_t redirectAligned;

    // target forced to a word boundary
    assign redirectAligned = {i_redirectPc[31:2], 2'b00};

    always_comb begin
        pcNext = pcR;
        // redirect wins over the sequential step
        if (i_redirect) begin
            pcNext = redirectAligned;
        end else if (i_takePc) begin
            pcNext = pcR + 32'd4;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            pcR <= RESET_PC;
        end else begin
            pcR <= pcNext;
        end
    end

    // fetch stage latches this on takePc
    assign o_pc = pcR;

endmodule

/* instrFetch.f */
hdl/fetchPkg.sv
hdl/programCounter.sv
hdl/instructionMemory.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/instrFetchTop.sv
testbench/instrFetch_assertions.sv
testbench/instrFetchTb.sv

/* runSim.sh */
#!/bin/sh
# build and run the instruction fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module instrFetchTb --Mdir obj_dir -o instrFetchTb \
    -f instrFetch.f; then
    echo "verilator build failed"
    exit 1
fi

simOutput=$(./obj_dir/instrFetchTb)
simStatus=$?
echo "$simOutput"

if [ "$simStatus" -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOutput" | grep -q "Simulation finished: PASS"; then
    exit 0
fi
exit 1

/* testbench/instrFetchTb.sv */
`timescale 1ns/1ps

module instrFetchTb;

    localparam int              RAM_DEPTH    = 64;
    localparam fetchPkg::addr_t RESET_PC     = 32'h0;
    localparam int              REDIRECTS    = 6;
    localparam int              AFTER_TARGET = 6;
    // items the tests wait for, one stale item per redirect included
    localparam int TOTAL_ITEMS = 124 + (REDIRECTS + 1) * (AFTER_TARGET + 1);
    localparam int CYCLE_LIMIT = 4 * TOTAL_ITEMS + 500;

    logic                    clock;
    logic                    reset;
    logic                    redirect;
    fetchPkg::addr_t         redirectPc;
    logic                    ready;
    logic                    valid;
    fetchPkg::decodedInstr_t decoded;

    int unsigned lcgState = 26533;
    logic        randomReady;
    string       currentTest;
    int          checkCount;
    int          errorCount;
    int          testsRun;
    int          testsFailed;
    int          checkBase;
    int          errorBase;
    // written by the comparing process
    int          itemsSeen;
    int          sinceTarget;
    int          negImmSeen;
    int          faultSeen;
    int          stallCycles;

    instrFetchTop #(
        .RAM_DEPTH(RAM_DEPTH),
        .RESET_PC (RESET_PC)
    ) i_dut (
        .i_clock     (clock),
        .i_reset     (reset),
        .i_redirect  (redirect),
        .i_redirectPc(redirectPc),
        .i_ready     (ready),
        .o_valid     (valid),
        .o_decoded   (decoded)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic int unsigned lcgNext();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState >> 16;
    endfunction

    // expected decode straight from the pattern and the MIPS field layout
    function automatic fetchPkg::decodedInstr_t expectDecode(input fetchPkg::addr_t pc);
        fetchPkg::decodedInstr_t d;
        fetchPkg::instrWord_t    w;
        logic [29:0]             wordNum;
        wordNum = pc >> 2;
        d.pc    = pc;
        d.fault = (wordNum >= RAM_DEPTH);
        w       = d.fault ? 32'h0 : fetchPkg::INIT_PATTERN[int'(wordNum[1:0])];
        d.opcode = fetchPkg::opcode_t'(w >> 26);
        d.rs     = fetchPkg::regIdx_t'(w >> 21);
        d.rt     = fetchPkg::regIdx_t'(w >> 16);
        d.rd     = fetchPkg::regIdx_t'(w >> 11);
        d.shamt  = fetchPkg::shamt_t'(w >> 6);
        d.funct  = fetchPkg::funct_t'(w);
        d.immExt = w & 32'h0000FFFF;
        if (w[15]) begin
            d.immExt = d.immExt | 32'hFFFF0000;
        end
        return d;
    endfunction

    task automatic checkDecoded(input string name, input fetchPkg::decodedInstr_t exp,
                                input fetchPkg::decodedInstr_t act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("FAILED %s: decoded expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic checkPc(input string name, input fetchPkg::addr_t exp,
                           input fetchPkg::addr_t act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("FAILED %s: pc expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic expectTrue(input logic cond, input string what);
        checkCount++;
        if (!cond) begin
            errorCount++;
            $display("ERROR %s: %s", currentTest, what);
        end
    endtask

    // one clock, consumer ready redrawn on the edge
    task automatic stepCycle();
        @(posedge clock);
        ready <= randomReady ? ((lcgNext() % 10) >= 3) : 1'b1;
    endtask

    task automatic sendRedirect(input fetchPkg::addr_t target);
        stepCycle();
        redirect   <= 1'b1;
        redirectPc <= target;
        stepCycle();
        redirect <= 1'b0;
        // lets the tracker clear sinceTarget first
        stepCycle();
    endtask

    task automatic waitItems(input int goal);
        while (itemsSeen < goal) begin
            stepCycle();
        end
    endtask

    task automatic waitAfterTarget(input int count);
        while (sinceTarget < count) begin
            stepCycle();
        end
    endtask

    task automatic startTest(input string name);
        currentTest = name;
        checkBase   = checkCount;
        errorBase   = errorCount;
    endtask

    task automatic endTest();
        // away from the rising edge, so this edge's compares are all counted
        @(negedge clock);
        testsRun++;
        if (errorCount != errorBase) begin
            testsFailed++;
        end
        $display("test %s: %0d checks, %0d errors", currentTest,
                 checkCount - checkBase, errorCount - errorBase);
    endtask

    // tracker of the expected pc, compares every accepted item
    always @(posedge clock) begin : compare
        fetchPkg::addr_t         nextPc;
        fetchPkg::addr_t         target;
        fetchPkg::addr_t         expPc;
        fetchPkg::decodedInstr_t expDec;
        logic                    pending;
        int                      oldLeft;
        if (reset) begin
            nextPc  = RESET_PC;
            pending = 1'b0;
            oldLeft = 0;
        end else begin
            if (valid && ready) begin
                // stale item in the output register goes out first
                if (pending && oldLeft == 0) begin
                    expPc       = target;
                    pending     = 1'b0;
                    sinceTarget <= 1;
                end else begin
                    expPc = nextPc;
                    if (pending) begin
                        oldLeft = oldLeft - 1;
                    end else begin
                        sinceTarget <= sinceTarget + 1;
                    end
                end
                expDec = expectDecode(expPc);
                checkPc(currentTest, expPc, decoded.pc);
                checkDecoded(currentTest, expDec, decoded);
                nextPc     = expPc + 32'd4;
                itemsSeen  <= itemsSeen + 1;
                negImmSeen <= negImmSeen + int'(decoded.immExt[31]);
                faultSeen  <= faultSeen + int'(decoded.fault);
            end
            if (valid && !ready) begin
                stallCycles <= stallCycles + 1;
            end
            if (redirect) begin
                pending     = 1'b1;
                target      = redirectPc & 32'hFFFFFFFC;
                oldLeft     = (valid && !ready) ? 1 : 0;
                sinceTarget <= 0;
            end
        end
    end

    initial begin : watchdog
        int cycleCount;
        cycleCount = 0;
        while (cycleCount < CYCLE_LIMIT) begin
            @(posedge clock);
            cycleCount++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin : stimulus
        int faultBase;
        reset       = 1'b1;
        redirect    = 1'b0;
        redirectPc  = '0;
        ready       = 1'b1;
        randomReady = 1'b0;
        currentTest = "none";
        checkCount  = 0;
        errorCount  = 0;
        testsRun    = 0;
        testsFailed = 0;
        itemsSeen   = 0;
        sinceTarget = 0;
        negImmSeen  = 0;
        faultSeen   = 0;
        stallCycles = 0;

        startTest("reset");
        @(posedge clock);
        repeat (15) begin
            @(posedge clock);
            expectTrue(valid == 1'b0, "o_valid was high during reset");
        end
        reset <= 1'b0;
        waitItems(8);
        endTest();

        startTest("decode");
        waitItems(24);
        expectTrue(negImmSeen > 0, "no item with a negative immediate was checked");
        endTest();

        startTest("backpressure");
        randomReady = 1'b1;
        waitItems(124);
        expectTrue(stallCycles > 0, "the consumer never stalled a valid output");
        endTest();

        startTest("redirect");
        repeat (REDIRECTS) begin
            sendRedirect(fetchPkg::addr_t'((lcgNext() % 64) * 4 + (lcgNext() % 4)));
            waitAfterTarget(AFTER_TARGET);
        end
        endTest();

        startTest("fault");
        faultBase = faultSeen;
        // words 62 and 63 in range, 64 onward past the end
        sendRedirect(32'd248);
        waitAfterTarget(AFTER_TARGET);
        expectTrue(faultSeen > faultBase, "no faulted item arrived past the memory end");
        endTest();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 testsRun, testsFailed, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* testbench/instrFetch_assertions.sv */
`timescale 1ns/1ps

module instrFetchAssertions (
    input logic                    i_clock,
    input logic                    i_reset,
    // wishbone between fetch stage and rom
    input fetchPkg::wbReq_t        i_wbReq,
    input fetchPkg::wbRsp_t        i_wbRsp,
    // consumer port
    input logic                    i_valid,
    input logic                    i_ready,
    input fetchPkg::decodedInstr_t i_decoded
);

    // slave answers one way only
    ackErrExclusive: assert property (@(posedge i_clock) disable iff (i_reset)
        !(i_wbRsp.ack && i_wbRsp.err))
        else $error("ack and err high in the same cycle");

    // answer only inside a strobed cycle
    answerInCycle: assert property (@(posedge i_clock) disable iff (i_reset)
        (i_wbRsp.ack || i_wbRsp.err) |-> (i_wbReq.cyc && i_wbReq.stb))
        else $error("bus answer without cyc and stb");

    // master holds its request until answered
    requestHeld: assert property (@(posedge i_clock) disable iff (i_reset)
        (i_wbReq.cyc && i_wbReq.stb && !(i_wbRsp.ack || i_wbRsp.err))
        |=> (i_wbReq.cyc && i_wbReq.stb && $stable(i_wbReq.adr)))
        else $error("request dropped or changed before the answer");

    // valid stays until taken
    validHeld: assert property (@(posedge i_clock) disable iff (i_reset)
        (i_valid && !i_ready) |=> i_valid)
        else $error("o_valid dropped without a handshake");

    // held output does not move
    decodedStable: assert property (@(posedge i_clock) disable iff (i_reset)
        (i_valid && !i_ready) |=> $stable(i_decoded))
        else $error("o_decoded changed while stalled");

endmodule

bind instrFetchTop instrFetchAssertions u_assertions (
    .i_clock  (i_clock),
    .i_reset  (i_reset),
    .i_wbReq  (wbReq),
    .i_wbRsp  (wbRsp),
    .i_valid  (o_valid),
    .i_ready  (i_ready),
    .i_decoded(o_decoded)
);
